/* logic/sd_cmd_pkg.sv */
`default_nettype none

package sd_cmd_pkg;

    // command and response frames are both 48 bits on the line
    localparam int CMD_FRAME_BITS = 48;

    // rising sd clock strobes allowed before the response start bit
    localparam int RESP_TIMEOUT_TICKS = 64;

    // command interrupt status bit positions
    localparam int INT_CC = 0;
    localparam int INT_CTO = 1;
    localparam int INT_CCRC = 2;
    localparam int INT_CIDX = 3;
    localparam int INT_CEND = 4;

    // x^7 + x^3 + 1
    localparam logic [6:0] CRC7_POLY = 7'h09;

    typedef logic [7:0] divisor_t;
    typedef logic [5:0] cmd_index_t;
    typedef logic [31:0] cmd_arg_t;
    typedef logic [6:0] crc7_t;

    // start bit, transmission bit, index and argument, the part ahead of the crc
    typedef logic [CMD_FRAME_BITS-9:0] cmd_frame_t;

    typedef logic [4:0] int_status_t;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT,
        DONE
    } cmd_state_t;

endpackage

`default_nettype wire

/* logic/sd_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface sd_cmd_if import sd_cmd_pkg::*; ();

    // request side, driven by the command master
    logic start;
    logic with_resp;
    cmd_frame_t frame;

    // result side, valid from finish until the next start
    logic finish;
    cmd_frame_t resp_frame;
    logic crc_ok;
    logic end_ok;
    logic timeout;

    modport master (
        output start, with_resp, frame,
        input finish, resp_frame, crc_ok, end_ok, timeout
    );

    modport host (
        input start, with_resp, frame,
        output finish, resp_frame, crc_ok, end_ok, timeout
    );

endinterface

`default_nettype wire

/* logic/sd_clock_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_clock_divider import sd_cmd_pkg::*; (
    input wire aclk,
    input wire rst_n_i,
    input wire divisor_t divisor_i,
    output logic sd_clk_o,
    output logic sd_rise_o,
    output logic sd_fall_o
);

    divisor_t cnt_q;

    // sd clock toggles every divisor_i + 1 cycles
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            sd_clk_o <= 1'b0;
            sd_rise_o <= 1'b0;
            sd_fall_o <= 1'b0;
        end else begin
            sd_rise_o <= 1'b0;
            sd_fall_o <= 1'b0;
            if (cnt_q == '0) begin
                cnt_q <= divisor_i;
                sd_clk_o <= !sd_clk_o;
                // strobes line up with the new clock level
                sd_rise_o <= !sd_clk_o;
                sd_fall_o <= sd_clk_o;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // strobes are exclusive and mark the actual edges of the pin level
    a_strobe_rise: assert property (
        @(posedge aclk) disable iff (!rst_n_i)
        sd_rise_o |-> !sd_fall_o && $rose(sd_clk_o)
    );

    a_strobe_fall: assert property (
        @(posedge aclk) disable iff (!rst_n_i)
        sd_fall_o |-> $fell(sd_clk_o)
    );

endmodule

`default_nettype wire

/* logic/sd_crc7.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_crc7 import sd_cmd_pkg::*; (
    input wire aclk,
    input wire rst_n_i,
    input wire clear_i,
    input wire enable_i,
    input wire bit_i,
    output crc7_t crc_o
);

    logic feedback;

    assign feedback = bit_i ^ crc_o[6];

    // serial crc7, one bit per enable, msb first
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            crc_o <= '0;
        end else if (clear_i) begin
            crc_o <= '0;
        end else if (enable_i) begin
            if (feedback) begin
                crc_o <= {crc_o[5:0], 1'b0} ^ CRC7_POLY;
            end else begin
                crc_o <= {crc_o[5:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

/* logic/sd_cmd_serial_host.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_serial_host import sd_cmd_pkg::*; (
    input wire aclk,
    input wire rst_n_i,
    input wire sd_rise_i,
    input wire sd_fall_i,
    input wire sd_cmd_i,
    sd_cmd_if.host cmd_bus,
    output logic sd_cmd_o,
    output logic sd_cmd_oe_o
);

    logic sending;
    logic waiting;
    logic receiving;
    logic with_resp_q;
    // bit position on the line, counts up to 48
    logic [5:0] bit_cnt;
    logic [$clog2(RESP_TIMEOUT_TICKS)-1:0] tick_cnt;
    cmd_frame_t tx_shift;
    crc7_t tx_crc;
    crc7_t rx_crc;
    crc7_t rx_crc_bits;
    logic [2:0] crc_pos;
    logic tx_crc_en;
    logic rx_crc_en;
    logic rx_start_bit;

    assign rx_start_bit = waiting && !sd_cmd_i;
    assign tx_crc_en = sd_fall_i && sending && (bit_cnt < $bits(cmd_frame_t));
    assign rx_crc_en = sd_rise_i &&
                       (rx_start_bit || (receiving && bit_cnt < $bits(cmd_frame_t)));

    // crc goes out msb first after the 40 frame bits
    assign crc_pos = 3'(CMD_FRAME_BITS - 2 - int'(bit_cnt));

    sd_crc7 tx_crc7 (
        .aclk     (aclk),
        .rst_n_i  (rst_n_i),
        .clear_i  (cmd_bus.start),
        .enable_i (tx_crc_en),
        .bit_i    (tx_shift[$bits(cmd_frame_t)-1]),
        .crc_o    (tx_crc)
    );

    sd_crc7 rx_crc7 (
        .aclk     (aclk),
        .rst_n_i  (rst_n_i),
        .clear_i  (cmd_bus.start),
        .enable_i (rx_crc_en),
        .bit_i    (sd_cmd_i),
        .crc_o    (rx_crc)
    );

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            sending <= 1'b0;
            waiting <= 1'b0;
            receiving <= 1'b0;
            with_resp_q <= 1'b0;
            bit_cnt <= '0;
            tick_cnt <= '0;
            sd_cmd_o <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
            cmd_bus.finish <= 1'b0;
            cmd_bus.timeout <= 1'b0;
            cmd_bus.crc_ok <= 1'b0;
            cmd_bus.end_ok <= 1'b0;
        end else begin
            cmd_bus.finish <= 1'b0;
            if (cmd_bus.start) begin
                sending <= 1'b1;
                waiting <= 1'b0;
                receiving <= 1'b0;
                with_resp_q <= cmd_bus.with_resp;
                bit_cnt <= '0;
                tick_cnt <= '0;
                cmd_bus.timeout <= 1'b0;
                cmd_bus.crc_ok <= 1'b0;
                cmd_bus.end_ok <= 1'b0;
            end else if (sending && sd_fall_i) begin
                if (bit_cnt == CMD_FRAME_BITS) begin
                    // end bit has been on the line for a full period
                    sending <= 1'b0;
                    sd_cmd_oe_o <= 1'b0;
                    sd_cmd_o <= 1'b1;
                    bit_cnt <= '0;
                    if (with_resp_q) begin
                        waiting <= 1'b1;
                    end else begin
                        cmd_bus.finish <= 1'b1;
                    end
                end else begin
                    sd_cmd_oe_o <= 1'b1;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt < $bits(cmd_frame_t)) begin
                        sd_cmd_o <= tx_shift[$bits(cmd_frame_t)-1];
                    end else if (bit_cnt < CMD_FRAME_BITS - 1) begin
                        sd_cmd_o <= tx_crc[crc_pos];
                    end else begin
                        sd_cmd_o <= 1'b1;
                    end
                end
            end else if (waiting && sd_rise_i) begin
                if (!sd_cmd_i) begin
                    // start bit counts as bit 0 of the response
                    waiting <= 1'b0;
                    receiving <= 1'b1;
                    bit_cnt <= 6'd1;
                end else if (tick_cnt == RESP_TIMEOUT_TICKS - 1) begin
                    waiting <= 1'b0;
                    cmd_bus.timeout <= 1'b1;
                    cmd_bus.finish <= 1'b1;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end else if (receiving && sd_rise_i) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CMD_FRAME_BITS - 1) begin
                    receiving <= 1'b0;
                    cmd_bus.end_ok <= sd_cmd_i;
                    cmd_bus.crc_ok <= (rx_crc_bits == rx_crc);
                    cmd_bus.finish <= 1'b1;
                end
            end
        end
    end

    // frame and response shift registers
    always_ff @(posedge aclk) begin
        if (cmd_bus.start) begin
            tx_shift <= cmd_bus.frame;
        end else if (tx_crc_en) begin
            tx_shift <= {tx_shift[$bits(cmd_frame_t)-2:0], 1'b0};
        end
        if (rx_crc_en) begin
            cmd_bus.resp_frame <= {cmd_bus.resp_frame[$bits(cmd_frame_t)-2:0], sd_cmd_i};
        end
        if (sd_rise_i && receiving && bit_cnt >= $bits(cmd_frame_t) &&
            bit_cnt < CMD_FRAME_BITS - 1) begin
            rx_crc_bits <= {rx_crc_bits[5:0], sd_cmd_i};
        end
    end

    // line is only ever enabled by a bit of the outgoing frame
    a_oe_only_sending: assert property (
        @(posedge aclk) disable iff (!rst_n_i)
        $rose(sd_cmd_oe_o) |-> $past(sending)
    );

endmodule

`default_nettype wire

/* logic/sd_cmd_master.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_master import sd_cmd_pkg::*; (
    input wire aclk,
    input wire rst_n_i,
    input wire start_i,
    input wire cmd_index_t cmd_index_i,
    input wire cmd_arg_t cmd_arg_i,
    input wire with_resp_i,
    input wire int_clear_i,
    sd_cmd_if.master cmd_bus,
    output logic busy_o,
    output int_status_t int_status_o,
    output cmd_arg_t response_o,
    output logic interrupt_o
);

    cmd_state_t state_q;
    cmd_index_t idx_q;
    cmd_arg_t arg_q;
    logic with_resp_q;
    int_status_t new_status;
    cmd_index_t resp_index;

    // index field sits right below start and transmission bits
    assign resp_index = cmd_bus.resp_frame[37:32];

    assign busy_o = (state_q != IDLE);
    assign interrupt_o = |int_status_o;

    assign cmd_bus.start = (state_q == SEND);
    assign cmd_bus.with_resp = with_resp_q;
    // start bit 0, transmission bit 1 for host to card
    assign cmd_bus.frame = {1'b0, 1'b1, idx_q, arg_q};

    // status bits raised by the command just finished
    always_comb begin
        new_status = '0;
        new_status[INT_CC] = 1'b1;
        if (cmd_bus.timeout) begin
            new_status[INT_CTO] = 1'b1;
        end else if (with_resp_q) begin
            new_status[INT_CCRC] = !cmd_bus.crc_ok;
            new_status[INT_CEND] = !cmd_bus.end_ok;
            new_status[INT_CIDX] = (resp_index != idx_q);
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            int_status_o <= '0;
            response_o <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= SEND;
                    end
                end
                SEND: state_q <= WAIT;
                WAIT: begin
                    if (cmd_bus.finish) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;
            endcase

            // busy falls and status updates on the same edge
            if (state_q == DONE) begin
                int_status_o <= (int_clear_i ? '0 : int_status_o) | new_status;
                if (with_resp_q && !cmd_bus.timeout) begin
                    response_o <= cmd_bus.resp_frame[31:0];
                end
            end else if (int_clear_i) begin
                int_status_o <= '0;
            end
        end
    end

    // command fields held for the whole command
    always_ff @(posedge aclk) begin
        if (state_q == IDLE && start_i) begin
            idx_q <= cmd_index_i;
            arg_q <= cmd_arg_i;
            with_resp_q <= with_resp_i;
        end
    end

    // a start while busy neither restarts the host nor touches the command
    a_start_ignored_busy: assert property (
        @(posedge aclk) disable iff (!rst_n_i)
        (start_i && busy_o) |=> (state_q != SEND) && $stable(idx_q) && $stable(arg_q)
    );

endmodule

`default_nettype wire

/* logic/sd_cmd_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_controller import sd_cmd_pkg::*; (
    input wire aclk,
    input wire rst_n_i,
    input wire divisor_t divisor_i,
    input wire start_i,
    input wire cmd_index_t cmd_index_i,
    input wire cmd_arg_t cmd_arg_i,
    input wire with_resp_i,
    input wire int_clear_i,
    output logic busy_o,
    output int_status_t int_status_o,
    output cmd_arg_t response_o,
    output logic interrupt_o,
    // sd command line
    output logic sd_clk_o,
    input wire sd_cmd_i,
    output logic sd_cmd_o,
    output logic sd_cmd_oe_o
);

    logic sd_rise;
    logic sd_fall;

    sd_cmd_if cmd_bus ();

    sd_clock_divider sd_clock_divider0 (
        .aclk      (aclk),
        .rst_n_i   (rst_n_i),
        .divisor_i (divisor_i),
        .sd_clk_o  (sd_clk_o),
        .sd_rise_o (sd_rise),
        .sd_fall_o (sd_fall)
    );

    sd_cmd_master sd_cmd_master0 (
        .aclk         (aclk),
        .rst_n_i      (rst_n_i),
        .start_i      (start_i),
        .cmd_index_i  (cmd_index_i),
        .cmd_arg_i    (cmd_arg_i),
        .with_resp_i  (with_resp_i),
        .int_clear_i  (int_clear_i),
        .cmd_bus      (cmd_bus.master),
        .busy_o       (busy_o),
        .int_status_o (int_status_o),
        .response_o   (response_o),
        .interrupt_o  (interrupt_o)
    );

    sd_cmd_serial_host sd_cmd_serial_host0 (
        .aclk        (aclk),
        .rst_n_i     (rst_n_i),
        .sd_rise_i   (sd_rise),
        .sd_fall_i   (sd_fall),
        .sd_cmd_i    (sd_cmd_i),
        .cmd_bus     (cmd_bus.host),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o)
    );

endmodule

`default_nettype wire

/* tb/sd_card_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
    input wire sd_clk_i,
    input wire sd_cmd_i,
    input wire sd_cmd_oe_i,
    input wire respond_i,
    input wire bad_crc_i,
    input wire bad_index_i,
    input wire bad_end_i,
    input wire [31:0] resp_arg_i,
    output logic sd_cmd_o,
    output logic [47:0] frame_o,
    output int frame_count_o,
    output int reply_count_o
);

    logic [47:0] cmd_bits;
    logic [39:0] resp_head;
    logic [47:0] resp_bits;
    logic [6:0] resp_crc;
    int bit_n;

    // crc7 over the 40 bits ahead of the crc, msb first
    function automatic logic [6:0] head_crc7(input logic [39:0] head);
        logic [6:0] crc;
        logic fb;
        int i;
        crc = '0;
        for (i = 39; i >= 0; i--) begin
            fb = head[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    initial begin
        sd_cmd_o = 1'b1;
        cmd_bits = '0;
        frame_o = '0;
        frame_count_o = 0;
        reply_count_o = 0;
        forever begin
            // host changes the line after a falling edge, so rising edges see stable bits
            for (bit_n = 0; bit_n < 48; bit_n++) begin
                @(posedge sd_clk_i);
                while (!sd_cmd_oe_i) begin
                    @(posedge sd_clk_i);
                end
                cmd_bits = {cmd_bits[46:0], sd_cmd_i};
            end
            frame_o = cmd_bits;
            frame_count_o++;
            if (respond_i) begin
                // transmission bit 0 for card to host
                resp_head = {1'b0, 1'b0, cmd_bits[45:40] ^ (bad_index_i ? 6'h01 : 6'h00),
                             resp_arg_i};
                resp_crc = head_crc7(resp_head);
                if (bad_crc_i) begin
                    resp_crc = resp_crc ^ 7'h01;
                end
                resp_bits = {resp_head, resp_crc, !bad_end_i};
                repeat (3) @(negedge sd_clk_i);
                reply_count_o++;
                for (bit_n = 47; bit_n >= 0; bit_n--) begin
                    @(negedge sd_clk_i);
                    sd_cmd_o = resp_bits[bit_n];
                end
                @(negedge sd_clk_i);
                sd_cmd_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_sd_cmd_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sd_cmd_controller import sd_cmd_pkg::*;;

    localparam int NUM_ROWS = 7;
    localparam int CYCLES_PER_ROW = 1000;
    localparam int RESET_CYCLES = 3;
    // every row gets its budget plus reset and a few spare cycles
    localparam int CYCLE_LIMIT = NUM_ROWS * CYCLES_PER_ROW + RESET_CYCLES + 20;

    localparam int_status_t ST_DONE = int_status_t'(1 << INT_CC);
    localparam int_status_t ST_TIMEOUT = int_status_t'(1 << INT_CTO);
    localparam int_status_t ST_CRC = int_status_t'(1 << INT_CCRC);
    localparam int_status_t ST_INDEX = int_status_t'(1 << INT_CIDX);
    localparam int_status_t ST_END = int_status_t'(1 << INT_CEND);

    typedef enum logic [2:0] {
        MODE_NORMAL,
        MODE_BAD_CRC,
        MODE_BAD_INDEX,
        MODE_BAD_END,
        MODE_SILENT
    } card_mode_t;

    typedef struct packed {
        cmd_index_t index;
        cmd_arg_t arg;
        logic with_resp;
        card_mode_t mode;
        cmd_arg_t resp_arg;
        logic double_start;
        int_status_t exp_status;
    } row_t;

    logic aclk;
    logic rst_n_i;
    divisor_t divisor_i;
    logic start_i;
    cmd_index_t cmd_index_i;
    cmd_arg_t cmd_arg_i;
    logic with_resp_i;
    logic int_clear_i;
    logic busy_o;
    int_status_t int_status_o;
    cmd_arg_t response_o;
    logic interrupt_o;
    logic sd_clk_o;
    wire sd_cmd_i;
    logic sd_cmd_o;
    logic sd_cmd_oe_o;

    logic card_respond;
    logic card_bad_crc;
    logic card_bad_index;
    logic card_bad_end;
    logic [31:0] card_resp_arg;
    logic [47:0] card_frame;
    int card_frames;
    int card_replies;

    row_t cmd_rows [NUM_ROWS];
    cmd_arg_t exp_response;
    int_status_t held_status;
    integer seed;
    int cycle_count = 0;
    int row_n;

    sd_cmd_controller uut (
        .aclk         (aclk),
        .rst_n_i      (rst_n_i),
        .divisor_i    (divisor_i),
        .start_i      (start_i),
        .cmd_index_i  (cmd_index_i),
        .cmd_arg_i    (cmd_arg_i),
        .with_resp_i  (with_resp_i),
        .int_clear_i  (int_clear_i),
        .busy_o       (busy_o),
        .int_status_o (int_status_o),
        .response_o   (response_o),
        .interrupt_o  (interrupt_o),
        .sd_clk_o     (sd_clk_o),
        .sd_cmd_i     (sd_cmd_i),
        .sd_cmd_o     (sd_cmd_o),
        .sd_cmd_oe_o  (sd_cmd_oe_o)
    );

    sd_card_model card (
        .sd_clk_i      (sd_clk_o),
        .sd_cmd_i      (sd_cmd_o),
        .sd_cmd_oe_i   (sd_cmd_oe_o),
        .respond_i     (card_respond),
        .bad_crc_i     (card_bad_crc),
        .bad_index_i   (card_bad_index),
        .bad_end_i     (card_bad_end),
        .resp_arg_i    (card_resp_arg),
        .sd_cmd_o      (sd_cmd_i),
        .frame_o       (card_frame),
        .frame_count_o (card_frames),
        .reply_count_o (card_replies)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #50 aclk = ~aclk;
        end
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: no end of the run after %0d clock cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "value check failed");
        end
    endtask

    // crc7 x^7 + x^3 + 1 over the 40 head bits msb first
    function automatic crc7_t crc7_of(input logic [39:0] head);
        crc7_t crc;
        logic fb;
        int i;
        crc = '0;
        for (i = 39; i >= 0; i--) begin
            fb = head[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    task automatic set_row(input int n, input cmd_index_t index, input logic with_resp,
                           input card_mode_t mode, input logic double_start,
                           input int_status_t exp_status);
        cmd_rows[n].index = index;
        cmd_rows[n].arg = $random(seed);
        cmd_rows[n].with_resp = with_resp;
        cmd_rows[n].mode = mode;
        cmd_rows[n].resp_arg = $random(seed);
        cmd_rows[n].double_start = double_start;
        cmd_rows[n].exp_status = exp_status;
    endtask

    task automatic run_row(input row_t row);
        int frames_before;
        int replies_before;
        logic [39:0] head;
        card_respond = (row.mode != MODE_SILENT);
        card_bad_crc = (row.mode == MODE_BAD_CRC);
        card_bad_index = (row.mode == MODE_BAD_INDEX);
        card_bad_end = (row.mode == MODE_BAD_END);
        card_resp_arg = row.resp_arg;
        frames_before = card_frames;
        replies_before = card_replies;
        cmd_index_i = row.index;
        cmd_arg_i = row.arg;
        with_resp_i = row.with_resp;
        start_i = 1'b1;
        @(negedge aclk);
        start_i = 1'b0;
        check_value(busy_o, 1, "busy_o after start");
        // sticky bits of the row before survive the new start
        check_value(int_status_o, held_status, "int_status_o after start");
        if (row.double_start) begin
            // another command while busy never reaches the card
            cmd_index_i = ~row.index;
            cmd_arg_i = ~row.arg;
            start_i = 1'b1;
            @(negedge aclk);
            start_i = 1'b0;
        end
        // clear while the command is still running
        int_clear_i = 1'b1;
        @(negedge aclk);
        int_clear_i = 1'b0;
        check_value(int_status_o, 0, "int_status_o after clear");
        check_value(interrupt_o, 0, "interrupt_o after clear");
        while (busy_o) begin
            @(negedge aclk);
        end
        if (row.with_resp && row.mode != MODE_SILENT) begin
            exp_response = row.resp_arg;
        end
        head = {1'b0, 1'b1, row.index, row.arg};
        check_value(card_frames - frames_before, 1, "frames seen by the card");
        check_value(card_frame, {head, crc7_of(head), 1'b1}, "frame captured by the card");
        check_value(card_replies - replies_before, (row.mode != MODE_SILENT) ? 1 : 0,
                    "responses sent by the card");
        check_value(int_status_o, row.exp_status, "int_status_o at completion");
        check_value(interrupt_o, 1, "interrupt_o at completion");
        check_value(response_o, exp_response, "response_o at completion");
        held_status = row.exp_status;
    endtask

    initial begin
        seed = 32'h805;
        rst_n_i = 1'b0;
        divisor_i = 8'd1;
        start_i = 1'b0;
        cmd_index_i = '0;
        cmd_arg_i = '0;
        with_resp_i = 1'b0;
        int_clear_i = 1'b0;
        card_respond = 1'b0;
        card_bad_crc = 1'b0;
        card_bad_index = 1'b0;
        card_bad_end = 1'b0;
        card_resp_arg = '0;
        exp_response = '0;
        held_status = '0;

        set_row(0, 6'd8, 1'b1, MODE_NORMAL, 1'b0, ST_DONE);
        set_row(1, 6'd17, 1'b1, MODE_BAD_CRC, 1'b0, ST_DONE | ST_CRC);
        set_row(2, 6'd55, 1'b1, MODE_BAD_INDEX, 1'b0, ST_DONE | ST_INDEX);
        set_row(3, 6'd13, 1'b1, MODE_BAD_END, 1'b0, ST_DONE | ST_END);
        set_row(4, 6'd41, 1'b1, MODE_SILENT, 1'b0, ST_DONE | ST_TIMEOUT);
        // no response expected so the card stays quiet
        set_row(5, 6'd0, 1'b0, MODE_SILENT, 1'b0, ST_DONE);
        set_row(6, 6'd2, 1'b1, MODE_NORMAL, 1'b1, ST_DONE);

        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        check_value(busy_o, 0, "busy_o in reset");
        check_value(sd_cmd_oe_o, 0, "sd_cmd_oe_o in reset");
        check_value(interrupt_o, 0, "interrupt_o in reset");
        check_value(sd_cmd_o, 1, "sd_cmd_o in reset");
        check_value(sd_clk_o, 0, "sd_clk_o in reset");
        check_value(int_status_o, 0, "int_status_o in reset");
        check_value(response_o, 0, "response_o in reset");
        rst_n_i = 1'b1;

        for (row_n = 0; row_n < NUM_ROWS; row_n++) begin
            run_row(cmd_rows[row_n]);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
logic/sd_cmd_pkg.sv
logic/sd_cmd_if.sv
logic/sd_clock_divider.sv
logic/sd_crc7.sv
logic/sd_cmd_serial_host.sv
logic/sd_cmd_master.sv
logic/sd_cmd_controller.sv
tb/sd_card_model.sv
tb/tb_sd_cmd_controller.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_sd_cmd_controller
FILELIST  := build.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
